// File: core_pkg.sv
/* core widths, reset PC and RV32I opcode constants
   instruction class and ALU op enums, packet structs for fetch, decode and retire */
`default_nettype none

package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_COUNT   = 32;
    localparam int QUEUE_DEPTH = 2;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1); // holds 0..QUEUE_DEPTH

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [XLEN-1:0]              addr_t;
    typedef logic [31:0]                  inst_word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    localparam addr_t RESET_PC = 32'h8000_0000;

    // major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [2:0] {
        CLASS_R,
        CLASS_I,      // OP_IMM and JALR
        CLASS_B,
        CLASS_U,      // LUI and AUIPC
        CLASS_J,
        CLASS_NONE    // anything else, retires without effect
    } inst_class_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        addr_t      pc;
        inst_word_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        word_t       imm;
        inst_class_t iclass;
        alu_op_t     alu_op;
    } decoded_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        logic     we;
        reg_idx_t rd;
        word_t    wdata;
    } retire_t;

endpackage

`default_nettype wire

// File: alu.sv
/* 32-bit integer ALU for the RV32I register and immediate operations */
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire alu_op_t op,
    output word_t        result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: regfile.sv
/* integer register file, 32 by 32, two read ports and one write port */
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           we,
    input  wire reg_idx_t waddr,
    input  wire word_t    wdata,
    input  wire reg_idx_t raddr1,
    input  wire reg_idx_t raddr2,
    output word_t         rdata1,
    output word_t         rdata2
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;   // x0 writes dropped
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: decoder.sv
/* instruction decoder: field slicing, immediate generation,
   instruction class and ALU operation */
`timescale 1ns/1ps
`default_nettype none

module decoder import core_pkg::*; (
    input  wire inst_word_t inst,
    output decoded_t        dec
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7_b5;
    inst_class_t iclass;
    word_t       imm;
    alu_op_t     alu_op;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];

    always_comb begin
        case (opcode)
            OPC_OP:               iclass = CLASS_R;
            OPC_OP_IMM, OPC_JALR: iclass = CLASS_I;
            OPC_BRANCH:           iclass = CLASS_B;
            OPC_LUI, OPC_AUIPC:   iclass = CLASS_U;
            OPC_JAL:              iclass = CLASS_J;
            default:              iclass = CLASS_NONE;
        endcase
    end

    always_comb begin
        case (iclass)
            CLASS_I: imm = {{20{inst[31]}}, inst[31:20]};
            CLASS_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            CLASS_U: imm = {inst[31:12], 12'b0};
            CLASS_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;   // R type has no immediate
        endcase
    end

    // branches, jumps and U types all use add
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (iclass == CLASS_R && funct7_b5) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;  // same bit for SRAI
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec.opcode = opcode;
        dec.funct3 = funct3;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.imm    = imm;
        dec.iclass = iclass;
        dec.alu_op = alu_op;
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
/* fetch unit: PC register, four-phase instruction memory handshake,
   redirect handling and hand-off of fetched packets to the queue */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    output logic             imem_req,
    output addr_t            imem_addr,
    input  wire              imem_ack,
    input  wire inst_word_t  imem_data,
    input  wire redirect_t   redirect,
    output logic             push_valid,
    output fetch_pkt_t       push_pkt,
    input  wire              push_ready
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,        // req high, waiting for ack
        ACK_LOW,    // req dropped, waiting for ack to fall
        HOLD        // packet offered to the queue
    } fetch_state_t;

    fetch_state_t state, state_next;
    addr_t        pc;          // next address to fetch
    addr_t        req_addr;    // address of the request on the bus
    addr_t        next_fetch;
    fetch_pkt_t   pkt;
    logic         discard;     // in-flight fetch belongs to the old path
    logic         raise;

    assign imem_req   = (state == REQ);
    assign imem_addr  = req_addr;
    assign push_valid = (state == HOLD);
    assign push_pkt   = pkt;
    assign next_fetch = redirect.valid ? redirect.target : pc;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    state_next = REQ;
            REQ:     if (imem_ack) state_next = ACK_LOW;
            ACK_LOW: begin
                // stale data is dropped here, never reaches the queue
                if (!imem_ack) state_next = (discard || redirect.valid) ? REQ : HOLD;
            end
            HOLD:    if (push_ready || redirect.valid) state_next = REQ;
            default: state_next = IDLE;
        endcase
    end

    assign raise = (state != REQ) && (state_next == REQ);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            pc       <= RESET_PC;
            req_addr <= RESET_PC;
            discard  <= 1'b0;
        end else begin
            state <= state_next;
            if (raise) begin
                req_addr <= next_fetch;       // stable until the next raise
                pc       <= next_fetch + 32'd4;
            end else if (redirect.valid) begin
                pc <= redirect.target;
            end
            if (raise)
                discard <= 1'b0;
            else if (redirect.valid && (state == REQ || state == ACK_LOW))
                discard <= 1'b1;
        end
    end

    // capture on the ack edge
    always_ff @(posedge clk) begin
        if (state == REQ && imem_ack) begin
            pkt.pc   <= req_addr;
            pkt.inst <= imem_data;
        end
    end

endmodule

`default_nettype wire

// File: fetch_queue.sv
/* fetch queue: two-entry circular FIFO of fetch packets with flush */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue import core_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire              flush,
    input  wire              push_valid,
    input  wire fetch_pkt_t  push_pkt,
    output logic             push_ready,
    output logic             pop_valid,
    output fetch_pkt_t       pop_pkt,
    input  wire              pop_ready
);

    fetch_pkt_t             mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] rd_ptr, wr_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   do_push, do_pop;

    function automatic logic [QUEUE_PTR_W-1:0] ptr_inc(input logic [QUEUE_PTR_W-1:0] p);
        ptr_inc = (p == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push_ready = (count != QUEUE_CNT_W'(QUEUE_DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_pkt    = mem[rd_ptr];
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush) mem[wr_ptr] <= push_pkt;
    end

endmodule

`default_nettype wire

// File: execute_unit.sv
/* execute unit: decode, register read, ALU operand selection, branch decision,
   redirect generation, register write-back and retire register */
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire              pop_valid,
    input  wire fetch_pkt_t  pop_pkt,
    output logic             pop_ready,
    output redirect_t        redirect,
    output retire_t          retire
);

    decoded_t dec;
    word_t    rs1_data, rs2_data;
    word_t    alu_a, alu_b, alu_result;
    word_t    wdata;
    addr_t    link_addr;
    addr_t    target;
    logic     accept, taken, wr_en, is_jalr, is_link;

    assign pop_ready = 1'b1;   // single-cycle execute, never stalls
    assign accept    = pop_valid && pop_ready;

    decoder u_decoder (
        .inst (pop_pkt.inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (accept && wr_en),
        .waddr  (dec.rd),
        .wdata  (wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    assign is_jalr = (dec.opcode == OPC_JALR);
    assign is_link = is_jalr || (dec.opcode == OPC_JAL);

    always_comb begin
        alu_a = rs1_data;
        alu_b = rs2_data;
        case (dec.iclass)
            CLASS_I: alu_b = dec.imm;
            CLASS_U: begin
                alu_a = (dec.opcode == OPC_LUI) ? '0 : pop_pkt.pc;
                alu_b = dec.imm;
            end
            CLASS_B, CLASS_J: begin   // ALU forms the target
                alu_a = pop_pkt.pc;
                alu_b = dec.imm;
            end
            default: ;
        endcase
    end

    always_comb begin
        taken = 1'b0;
        case (dec.iclass)
            CLASS_B: begin
                case (dec.funct3)
                    3'b000:  taken = (rs1_data == rs2_data);
                    3'b001:  taken = (rs1_data != rs2_data);
                    3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
                    3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
                    3'b110:  taken = (rs1_data < rs2_data);
                    3'b111:  taken = (rs1_data >= rs2_data);
                    default: taken = 1'b0;
                endcase
            end
            CLASS_J: taken = 1'b1;
            CLASS_I: taken = is_jalr;
            default: taken = 1'b0;
        endcase
    end

    assign link_addr = pop_pkt.pc + 32'd4;
    assign target    = is_jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;
    assign wr_en     = (dec.iclass == CLASS_R) || (dec.iclass == CLASS_I) ||
                       (dec.iclass == CLASS_U) || (dec.iclass == CLASS_J);
    assign wdata     = is_link ? link_addr : alu_result;

    // flushes the queue and steers fetch on the accepting edge
    assign redirect.valid  = accept && taken;
    assign redirect.target = target;

    always_ff @(posedge clk) begin
        if (reset)
            retire.valid <= 1'b0;
        else
            retire.valid <= accept;
        retire.pc    <= pop_pkt.pc;
        retire.we    <= wr_en;
        retire.rd    <= dec.rd;
        retire.wdata <= wdata;
    end

endmodule

`default_nettype wire

// File: rv_core.sv
/* RV32I core top: fetch unit, fetch queue and execute unit */
`timescale 1ns/1ps
`default_nettype none

module rv_core import core_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    output logic             imem_req,
    output addr_t            imem_addr,
    input  wire              imem_ack,
    input  wire inst_word_t  imem_data,
    output retire_t          retire
);

    logic       push_valid, push_ready;
    fetch_pkt_t push_pkt;
    logic       pop_valid, pop_ready;
    fetch_pkt_t pop_pkt;
    redirect_t  redirect;

    fetch_unit u_fetch_unit (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_data  (imem_data),
        .redirect   (redirect),
        .push_valid (push_valid),
        .push_pkt   (push_pkt),
        .push_ready (push_ready)
    );

    fetch_queue u_fetch_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (redirect.valid),
        .push_valid (push_valid),
        .push_pkt   (push_pkt),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_pkt    (pop_pkt),
        .pop_ready  (pop_ready)
    );

    execute_unit u_execute_unit (
        .clk       (clk),
        .reset     (reset),
        .pop_valid (pop_valid),
        .pop_pkt   (pop_pkt),
        .pop_ready (pop_ready),
        .redirect  (redirect),
        .retire    (retire)
    );

endmodule

`default_nettype wire

// File: tb_rv_core.sv
/* testbench for rv_core: four-phase instruction memory with random ack delay,
   program table with expected retire values, handshake monitor and watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import core_pkg::*; ();

    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 8;
    localparam int ROW_CYCLES   = 40;   // watchdog budget per table row

    typedef struct packed {
        inst_word_t inst;
        logic       ret;    // expected to retire
        logic       we;
        reg_idx_t   rd;
        word_t      wdata;
    } row_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       imem_req;
    addr_t      imem_addr;
    logic       imem_ack;
    inst_word_t imem_data;
    retire_t    retire;

    row_t   rows[$];
    int     retire_rows = 0;
    logic   first_req = 1'b1;
    integer seed = 32'h8bd1;

    always #CLK_HALF clk = ~clk;

    rv_core i_dut (
        .clk       (clk),
        .reset     (reset),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .retire    (retire)
    );

    function automatic inst_word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                          input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                          input reg_idx_t rd, input reg_idx_t rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_word_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                          input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_word_t u_type(input logic [6:0] opc, input reg_idx_t rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic inst_word_t j_type(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // words outside the program carry an opcode ending in 00, never a kept one
    function automatic inst_word_t fetch_word(input addr_t addr);
        addr_t offset;
        offset = addr - RESET_PC;
        if (offset[1:0] == 2'b00 && (offset >> 2) < addr_t'(rows.size()))
            return rows[offset >> 2].inst;
        return {addr[31:2], 2'b00};
    endfunction

    task automatic add_row(input inst_word_t inst, input logic ret, input logic we,
                           input reg_idx_t rd, input word_t wdata);
        row_t r;
        r.inst  = inst;
        r.ret   = ret;
        r.we    = we;
        r.rd    = rd;
        r.wdata = wdata;
        rows.push_back(r);
        if (ret)
            retire_rows++;
    endtask

    task automatic put_write(input inst_word_t inst, input reg_idx_t rd, input word_t wdata);
        add_row(inst, 1'b1, 1'b1, rd, wdata);
    endtask

    task automatic put_nowrite(input inst_word_t inst);
        add_row(inst, 1'b1, 1'b0, '0, '0);
    endtask

    task automatic put_skipped(input inst_word_t inst);
        add_row(inst, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic stop_failed();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_pc(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
            stop_failed();
        end
    endtask

    task automatic compare_write(input reg_idx_t got_rd, input word_t got_data,
                                 input reg_idx_t exp_rd, input word_t exp_data);
        if (got_rd !== exp_rd || got_data !== exp_data) begin
            $display("Mismatch at %0t ns: write-back, expected x%0d = %h, got x%0d = %h",
                     $time, exp_rd, exp_data, got_rd, got_data);
            stop_failed();
        end
    endtask

    task automatic expect_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, expected %b, got %b", $time, what, exp, got);
            stop_failed();
        end
    endtask

    // x1 = 5 and x2 = -3 feed most of the checks below
    task automatic load_program();
        put_write(i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'h0000_0005);
        put_write(i_type(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'hffd), 5'd2, 32'hffff_fffd);
        put_write(i_type(OPC_OP_IMM, 3'b010, 5'd3, 5'd2, 12'd0), 5'd3, 32'h0000_0001);
        put_write(i_type(OPC_OP_IMM, 3'b011, 5'd4, 5'd2, 12'd5), 5'd4, 32'h0000_0000);
        put_write(i_type(OPC_OP_IMM, 3'b100, 5'd5, 5'd1, 12'h0ff), 5'd5, 32'h0000_00fa);
        put_write(i_type(OPC_OP_IMM, 3'b110, 5'd6, 5'd1, 12'h030), 5'd6, 32'h0000_0035);
        put_write(i_type(OPC_OP_IMM, 3'b111, 5'd7, 5'd2, 12'h00f), 5'd7, 32'h0000_000d);
        put_write(i_type(OPC_OP_IMM, 3'b001, 5'd8, 5'd1, 12'h004), 5'd8, 32'h0000_0050);
        put_write(i_type(OPC_OP_IMM, 3'b101, 5'd9, 5'd2, 12'h01c), 5'd9, 32'h0000_000f);
        put_write(i_type(OPC_OP_IMM, 3'b101, 5'd10, 5'd2, 12'h401), 5'd10, 32'hffff_fffe);
        put_write(u_type(OPC_LUI, 5'd11, 20'h12345), 5'd11, 32'h1234_5000);
        put_write(u_type(OPC_AUIPC, 5'd12, 20'h00001), 5'd12, 32'h8000_102c);
        // register-register ops
        put_write(r_type(7'h00, 3'b000, 5'd13, 5'd1, 5'd2), 5'd13, 32'h0000_0002);
        put_write(r_type(7'h20, 3'b000, 5'd14, 5'd2, 5'd1), 5'd14, 32'hffff_fff8);
        put_write(r_type(7'h00, 3'b001, 5'd15, 5'd1, 5'd1), 5'd15, 32'h0000_00a0);
        put_write(r_type(7'h00, 3'b010, 5'd16, 5'd2, 5'd1), 5'd16, 32'h0000_0001);
        put_write(r_type(7'h00, 3'b011, 5'd17, 5'd2, 5'd1), 5'd17, 32'h0000_0000);
        put_write(r_type(7'h00, 3'b100, 5'd18, 5'd1, 5'd2), 5'd18, 32'hffff_fff8);
        put_write(r_type(7'h00, 3'b101, 5'd19, 5'd2, 5'd1), 5'd19, 32'h07ff_ffff);
        put_write(r_type(7'h20, 3'b101, 5'd20, 5'd14, 5'd13), 5'd20, 32'hffff_fffe);
        put_write(r_type(7'h00, 3'b110, 5'd21, 5'd1, 5'd6), 5'd21, 32'h0000_0035);
        put_write(r_type(7'h00, 3'b111, 5'd22, 5'd2, 5'd5), 5'd22, 32'h0000_00f8);
        put_write(r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd1), 5'd0, 32'h0000_000a);
        put_write(r_type(7'h00, 3'b000, 5'd23, 5'd0, 5'd1), 5'd23, 32'h0000_0005);
        // branches, the skipped slots sit on the fall-through path
        put_nowrite(b_type(3'b000, 5'd1, 5'd2, 13'd8));
        put_nowrite(b_type(3'b001, 5'd1, 5'd2, 13'd12));
        put_skipped(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd1));
        put_skipped(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd2));
        put_nowrite(b_type(3'b100, 5'd2, 5'd1, 13'd8));
        put_skipped(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd3));
        put_nowrite(b_type(3'b101, 5'd2, 5'd1, 13'd8));
        put_nowrite(b_type(3'b110, 5'd1, 5'd2, 13'd8));
        put_skipped(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd4));
        put_nowrite(b_type(3'b111, 5'd1, 5'd2, 13'd8));
        // jumps
        put_write(j_type(5'd25, 21'd12), 5'd25, 32'h8000_008c);
        put_skipped(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd5));
        put_skipped(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd6));
        put_write(u_type(OPC_AUIPC, 5'd26, 20'h00000), 5'd26, 32'h8000_0094);
        put_write(i_type(OPC_JALR, 3'b000, 5'd27, 5'd26, 12'd17), 5'd27, 32'h8000_009c);
        put_skipped(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd7));
        put_skipped(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd8));
        put_write(i_type(OPC_OP_IMM, 3'b000, 5'd28, 5'd27, 12'd1), 5'd28, 32'h8000_009d);
        put_write(j_type(5'd0, 21'd0), 5'd0, 32'h8000_00ac);   // parks on itself
    endtask

    initial begin : stimulus
        int    row_idx;
        int    seen;
        addr_t exp_pc;
        reset     = 1'b1;
        imem_ack  = 1'b0;
        imem_data = '0;
        load_program();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            expect_bit("imem_req during reset", imem_req, 1'b0);
            expect_bit("retire.valid during reset", retire.valid, 1'b0);
        end
        reset   = 1'b0;
        row_idx = 0;
        seen    = 0;
        while (seen < retire_rows) begin
            @(negedge clk);
            if (retire.valid) begin
                while (!rows[row_idx].ret)
                    row_idx++;
                exp_pc = RESET_PC + addr_t'(4 * row_idx);
                check_pc("retire pc", retire.pc, exp_pc);
                expect_bit("retire we", retire.we, rows[row_idx].we);
                if (rows[row_idx].we)
                    compare_write(retire.rd, retire.wdata, rows[row_idx].rd, rows[row_idx].wdata);
                row_idx++;
                seen++;
            end
        end
        $display("TB PASSED");
        $finish;
    end

    // memory side of the four-phase port
    initial begin : imem_model
        int wait_cycles;
        int drop_cycles;
        forever begin
            @(negedge clk);
            if (!reset && imem_req && !imem_ack) begin
                if (first_req) begin
                    check_pc("first request address", imem_addr, RESET_PC);
                    first_req = 1'b0;
                end
                wait_cycles = $unsigned($random(seed)) % 4;
                repeat (wait_cycles) @(negedge clk);
                imem_data = fetch_word(imem_addr);
                imem_ack  = 1'b1;
                while (imem_req)
                    @(negedge clk);
                drop_cycles = 1 + $unsigned($random(seed)) % 2;
                repeat (drop_cycles) @(negedge clk);
                imem_ack = 1'b0;
            end
        end
    end

    always @(posedge imem_req) begin
        if (!reset && imem_ack !== 1'b0) begin
            $display("Handshake error at %0t ns: imem_req rose while imem_ack was high", $time);
            stop_failed();
        end
    end

    always @(negedge imem_req) begin
        if (!reset && imem_ack !== 1'b1) begin
            $display("Handshake error at %0t ns: imem_req fell before imem_ack rose", $time);
            stop_failed();
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = RESET_CYCLES + ROW_CYCLES * rows.size();
        repeat (limit) @(posedge clk);
        $display("Timeout: the retire table was not finished within %0d cycles", limit);
        stop_failed();
    end

endmodule

`default_nettype wire

// File: build.f
core_pkg.sv
alu.sv
regfile.sv
decoder.sv
fetch_unit.sv
fetch_queue.sv
execute_unit.sv
rv_core.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - core_pkg.sv
  - alu.sv
  - regfile.sv
  - decoder.sv
  - fetch_unit.sv
  - fetch_queue.sv
  - execute_unit.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv
